/* vlog.f */
logic/rv32i_pkg.sv
logic/execute_stage.sv
logic/ex_mem_reg.sv
logic/mem_stage.sv
logic/backend_top.sv
sim/backend_checker.sv
sim/backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module backend_tb -o backend_sim \
    && ./obj_dir/backend_sim | tee sim.log
grep -q "^TEST OK$" sim.log && exit 0 || exit 1

/* sim/backend_tb.sv */
module backend_tb
import rv32i_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WARM_ISSUES     = 200;
    localparam int PRESS_ISSUES    = 600;
    localparam int TOTAL_ISSUES    = WARM_ISSUES + PRESS_ISSUES;
    localparam int WATCHDOG_CYCLES = TOTAL_ISSUES * 20;

    logic        clk;
    logic        rst;
    logic        issue_valid;
    logic        issue_ready;
    id_ex_t      issue;
    logic        wb_valid;
    logic        wb_ready;
    wb_t         wb;
    logic        timed;
    logic        bp_on;
    logic [31:0] lcg_state;
    int          n_issue;
    int          n_wb;
    int          n_err;
    int          n_pending;

    alu_ops    alu_list [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                 alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    cmp_ops    cmp_list [6]  = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
    mem_funct3 mem_list [5]  = '{mem_b, mem_h, mem_w, mem_bu, mem_hu};

    backend_top DUT (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_ready_o (issue_ready),
        .issue_i       (issue),
        .wb_valid_o    (wb_valid),
        .wb_ready_i    (wb_ready),
        .wb_o          (wb)
    );

    backend_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_ready_i (issue_ready),
        .issue_i       (issue),
        .wb_valid_i    (wb_valid),
        .wb_ready_i    (wb_ready),
        .wb_i          (wb),
        .timed_i       (timed),
        .issued_o      (n_issue),
        .retired_o     (n_wb),
        .errors_o      (n_err),
        .pending_o     (n_pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic id_ex_t make_issue();
        id_ex_t      b;
        logic [31:0] r;
        rv32i_word   addr;
        b         = '0;
        b.pc      = next_rand() & 32'hffff_fffc;
        b.rs1_val = next_rand();
        b.rs2_val = next_rand();
        r         = next_rand();
        b.imm     = {{20{r[11]}}, r[11:0]};
        b.rd      = r[16:12];
        b.ctrl.halt = (r[31:28] == 4'h0);
        // Equal operands now and then for the equality branches
        if (r[27:25] == 3'b000) begin
            b.rs2_val = b.rs1_val;
        end
        r = next_rand();
        b.ctrl.alu_op   = alu_list[(r >> 8) % 10];
        b.ctrl.cmp_op   = cmp_list[(r >> 16) % 6];
        b.ctrl.mem_size = mem_w;
        case (r[2:0])
            3'd0: b.ctrl.reg_write = 1'b1;
            3'd1: begin
                b.ctrl.alu_src_imm = 1'b1;
                b.ctrl.reg_write   = 1'b1;
            end
            3'd2: begin
                // auipc
                b.ctrl.alu_op      = alu_add;
                b.ctrl.alu_src_pc  = 1'b1;
                b.ctrl.alu_src_imm = 1'b1;
                b.ctrl.reg_write   = 1'b1;
            end
            3'd3: b.ctrl.is_branch = 1'b1;
            3'd4: begin
                b.ctrl.is_jal    = 1'b1;
                b.ctrl.reg_write = 1'b1;
            end
            3'd5: begin
                b.ctrl.is_jalr   = 1'b1;
                b.ctrl.reg_write = 1'b1;
            end
            default: begin
                b.ctrl.alu_op      = alu_add;
                b.ctrl.alu_src_imm = 1'b1;
                b.ctrl.mem_read    = !r[0];
                b.ctrl.mem_write   = r[0];
                b.ctrl.reg_write   = !r[0];
                b.ctrl.mem_size    = r[0] ? mem_list[(r >> 12) % 3] : mem_list[(r >> 12) % 5];
                r    = next_rand();
                // Half the accesses share a small window so loads see earlier stores
                addr = r[31] ? {22'b0, r[9:0]} : {22'b0, 4'h8, r[5:0]};
                if (b.ctrl.mem_size == mem_w) begin
                    addr[1:0] = 2'b00;
                end else if (b.ctrl.mem_size inside {mem_h, mem_hu}) begin
                    addr[0] = 1'b0;
                end
                b.rs1_val = addr - b.imm;
            end
        endcase
        return b;
    endfunction

    task automatic tick();
        logic [31:0] r;
        @(negedge clk);
        if (bp_on) begin
            r        = next_rand();
            wb_ready = r[31];
        end
    endtask

    // Entered on a falling edge and returns on the falling edge after the transfer
    task automatic send_issue(input id_ex_t b, input int gap);
        logic accepted;
        issue_valid = 1'b0;
        repeat (gap) tick();
        issue_valid = 1'b1;
        issue       = b;
        accepted    = 1'b0;
        while (!accepted) begin
            // Ready has settled well before the rising edge
            #1;
            accepted = issue_ready;
            @(posedge clk);
            tick();
        end
    endtask

    initial begin
        logic [31:0] r;
        rst         = 1'b1;
        // A request held during reset must not reach the writeback port
        issue_valid = 1'b1;
        issue       = '0;
        wb_ready    = 1'b1;
        timed       = 1'b0;
        bp_on       = 1'b0;
        lcg_state   = 32'hf190;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        timed = 1'b1;
        for (int i = 0; i < WARM_ISSUES; i++) begin
            send_issue(make_issue(), 0);
        end
        issue_valid = 1'b0;
        while (n_pending != 0) begin
            tick();
        end
        timed = 1'b0;
        bp_on = 1'b1;
        for (int i = 0; i < PRESS_ISSUES; i++) begin
            r = next_rand();
            send_issue(make_issue(), (r[31:30] == 2'b00) ? 1 : 0);
        end
        issue_valid = 1'b0;
        bp_on       = 1'b0;
        wb_ready    = 1'b1;
        while (n_pending != 0) begin
            tick();
        end
        repeat (4) tick();
        if (n_issue != TOTAL_ISSUES || n_wb != n_issue) begin
            $display("%0d issues accepted but %0d writebacks seen", n_issue, n_wb);
        end
        $display("summary: %0d issued, %0d written back, %0d errors", n_issue, n_wb, n_err);
        if (n_err == 0 && n_issue == TOTAL_ISSUES && n_wb == n_issue) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: pipeline still busy after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : backend_tb

/* sim/backend_checker.sv */
module backend_checker
import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   issue_valid_i,
    input  logic   issue_ready_i,
    input  id_ex_t issue_i,
    input  logic   wb_valid_i,
    input  logic   wb_ready_i,
    input  wb_t    wb_i,
    input  logic   timed_i,
    output int     issued_o,
    output int     retired_o,
    output int     errors_o,
    output int     pending_o
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [DMEM_IDX_W+1:0] baddr_t;

    logic [7:0] shadow [DMEM_WORDS*4];
    id_ex_t     issue_q [$];
    int         stamp_q [$];
    logic       timed_q [$];
    int         cycle = 0;
    int         issued = 0;
    int         retired = 0;
    int         errors = 0;
    int         pending = 0;
    logic       rst_q = 1'b0;

    assign issued_o  = issued;
    assign retired_o = retired;
    assign errors_o  = errors;
    assign pending_o = pending;

    initial begin
        for (int i = 0; i < DMEM_WORDS * 4; i++) begin
            shadow[i] = 8'h00;
        end
    end

    function automatic int access_bytes(input mem_funct3 size);
        case (size)
            mem_b, mem_bu: return 1;
            mem_h, mem_hu: return 2;
            default:       return 4;
        endcase
    endfunction

    // Little endian with the upper bytes left zero
    function automatic rv32i_word read_bytes(input baddr_t at, input int n);
        rv32i_word v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = shadow[at];
            at = at + 1'b1;
        end
        return v;
    endfunction

    function automatic wb_t expected_wb(input id_ex_t t);
        wb_t        e;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  res;
        rv32i_word  raw;
        logic [4:0] sh;
        logic       take;
        a  = t.ctrl.alu_src_pc ? t.pc : t.rs1_val;
        b  = t.ctrl.alu_src_imm ? t.imm : t.rs2_val;
        sh = b[4:0];
        case (t.ctrl.alu_op)
            alu_add:  res = a + b;
            alu_sub:  res = a + ~b + 32'd1;
            alu_sll:  res = a << sh;
            alu_slt:  res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
            alu_xor:  res = a ^ b;
            alu_srl:  res = a >> sh;
            // Vacated bits take the sign
            alu_sra:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            alu_or:   res = a | b;
            default:  res = a & b;
        endcase
        // Signed order by flipping the sign bits
        case (t.ctrl.cmp_op)
            cmp_beq:  take = t.rs1_val == t.rs2_val;
            cmp_bne:  take = t.rs1_val != t.rs2_val;
            cmp_blt:  take = (t.rs1_val ^ 32'h8000_0000) < (t.rs2_val ^ 32'h8000_0000);
            cmp_bge:  take = (t.rs1_val ^ 32'h8000_0000) >= (t.rs2_val ^ 32'h8000_0000);
            cmp_bltu: take = t.rs1_val < t.rs2_val;
            default:  take = t.rs1_val >= t.rs2_val;
        endcase
        raw = read_bytes(baddr_t'(res), access_bytes(t.ctrl.mem_size));
        e.pc        = t.pc;
        e.rd        = t.rd;
        e.reg_write = t.ctrl.reg_write && (t.rd != 5'd0);
        if (t.ctrl.is_jal || t.ctrl.is_jalr) begin
            e.wb_data = t.pc + 32'd4;
        end else if (t.ctrl.mem_read) begin
            case (t.ctrl.mem_size)
                mem_b:   e.wb_data = {{24{raw[7]}}, raw[7:0]};
                mem_h:   e.wb_data = {{16{raw[15]}}, raw[15:0]};
                default: e.wb_data = raw;
            endcase
        end else begin
            e.wb_data = res;
        end
        e.redirect_en = t.ctrl.is_jal || t.ctrl.is_jalr || (t.ctrl.is_branch && take);
        e.redirect_pc = t.ctrl.is_jalr ? ((t.rs1_val + t.imm) & ~32'h1) : t.pc + t.imm;
        e.halt        = t.ctrl.halt;
        return e;
    endfunction

    task automatic apply_store(input id_ex_t t);
        baddr_t at;
        at = baddr_t'(t.rs1_val + t.imm);
        for (int k = 0; k < access_bytes(t.ctrl.mem_size); k++) begin
            shadow[at] = t.rs2_val[8*k +: 8];
            at = at + 1'b1;
        end
    endtask

    task automatic check_field(input string name, input rv32i_word exp, input rv32i_word act);
        if (exp !== act) begin
            $display("error at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        id_ex_t t;
        wb_t    e;
        int     stamp;
        cycle++;
        if (rst_q && !rst) begin
            check_field("wb_valid_o after reset", 32'd0, 32'(wb_valid_i));
        end
        if (!rst) begin
            // Two records in flight fill both stages
            check_field("issue_ready_o", 32'((issue_q.size() < 2) || wb_ready_i),
                        32'(issue_ready_i));
        end
        if (!rst && issue_valid_i && issue_ready_i) begin
            issue_q.push_back(issue_i);
            stamp_q.push_back(cycle);
            timed_q.push_back(timed_i);
            issued++;
        end
        if (!rst && wb_valid_i && wb_ready_i) begin
            if (issue_q.size() == 0) begin
                $display("error at time %0t: writeback arrived with no issue waiting", $time);
                errors++;
            end else begin
                t     = issue_q.pop_front();
                stamp = stamp_q.pop_front();
                e     = expected_wb(t);
                if (timed_q.pop_front()) begin
                    check_field("writeback latency", 32'd2, cycle - stamp);
                end
                check_field("wb_o.pc", e.pc, wb_i.pc);
                check_field("wb_o.rd", 32'(e.rd), 32'(wb_i.rd));
                check_field("wb_o.reg_write", 32'(e.reg_write), 32'(wb_i.reg_write));
                check_field("wb_o.wb_data", e.wb_data, wb_i.wb_data);
                check_field("wb_o.redirect_en", 32'(e.redirect_en), 32'(wb_i.redirect_en));
                check_field("wb_o.redirect_pc", e.redirect_pc, wb_i.redirect_pc);
                check_field("wb_o.halt", 32'(e.halt), 32'(wb_i.halt));
                if (t.ctrl.mem_write) begin
                    apply_store(t);
                end
                retired++;
            end
        end
        pending = issue_q.size();
        rst_q   = rst;
    end

endmodule : backend_checker

/* logic/backend_top.sv */
module backend_top
import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   issue_valid_i,
    output logic   issue_ready_o,
    input  id_ex_t issue_i,

    output logic   wb_valid_o,
    input  logic   wb_ready_i,
    output wb_t    wb_o
);

    logic    ex_valid;
    logic    ex_ready;
    ex_mem_t ex_rec;
    logic    mem_valid;
    logic    mem_ready;
    ex_mem_t mem_rec;

    execute_stage u_execute (
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .ex_valid_o    (ex_valid),
        .ex_ready_i    (ex_ready),
        .ex_o          (ex_rec)
    );

    ex_mem_reg u_ex_mem (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (ex_valid),
        .in_ready_o  (ex_ready),
        .in_i        (ex_rec),
        .out_valid_o (mem_valid),
        .out_ready_i (mem_ready),
        .out_o       (mem_rec)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (mem_valid),
        .in_ready_o (mem_ready),
        .in_i       (mem_rec),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb_o)
    );

endmodule : backend_top

/* logic/mem_stage.sv */
module mem_stage
import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  ex_mem_t in_i,

    output logic    wb_valid_o,
    input  logic    wb_ready_i,
    output wb_t     wb_o
);

    rv32i_word dmem [DMEM_WORDS];

    logic      accept;
    dmem_idx_t idx;
    logic [1:0] lane;
    byte_en_t  st_be;
    rv32i_word st_data;
    rv32i_word rd_word;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    rv32i_word load_val;
    wb_t       wb_next;
    wb_t       wb_q;
    logic      wb_valid_q;

    assign in_ready_o = !wb_valid_q || wb_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    // Word index wraps with the memory size
    assign idx  = in_i.alu_out[DMEM_IDX_W+1:2];
    assign lane = in_i.alu_out[1:0];

    // Store lanes
    always_comb begin
        unique case (in_i.ctrl.mem_size)
            mem_b, mem_bu: begin
                st_be   = byte_en_t'(4'b0001 << lane);
                st_data = {4{in_i.rs2_val[7:0]}};
            end
            mem_h, mem_hu: begin
                st_be   = byte_en_t'(4'b0011 << {lane[1], 1'b0});
                st_data = {2{in_i.rs2_val[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = in_i.rs2_val;
            end
        endcase
    end

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && in_i.ctrl.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (st_be[b]) begin
                    dmem[idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
        end
    end

    // Load lane pick and extension
    assign rd_word   = dmem[idx];
    assign byte_lane = rd_word[8*lane +: 8];
    assign half_lane = rd_word[16*lane[1] +: 16];

    always_comb begin
        unique case (in_i.ctrl.mem_size)
            mem_b:   load_val = {{24{byte_lane[7]}}, byte_lane};
            mem_bu:  load_val = {24'b0, byte_lane};
            mem_h:   load_val = {{16{half_lane[15]}}, half_lane};
            mem_hu:  load_val = {16'b0, half_lane};
            default: load_val = rd_word;
        endcase
    end

    always_comb begin
        wb_next.pc          = in_i.pc;
        wb_next.rd          = in_i.rd;
        wb_next.reg_write   = in_i.ctrl.reg_write && (in_i.rd != '0);
        if (in_i.ctrl.is_jal || in_i.ctrl.is_jalr) begin
            wb_next.wb_data = in_i.pc + 32'd4;
        end else if (in_i.ctrl.mem_read) begin
            wb_next.wb_data = load_val;
        end else begin
            wb_next.wb_data = in_i.alu_out;
        end
        wb_next.redirect_en = in_i.redirect_en;
        wb_next.redirect_pc = in_i.redirect_pc;
        wb_next.halt        = in_i.ctrl.halt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
            wb_q       <= '0;
        end else begin
            if (in_ready_o) begin
                wb_valid_q <= in_valid_i;
            end
            if (accept) begin
                wb_q <= wb_next;
            end
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;

    // Alignment and control sanity from execute
    assert property (@(posedge clk) disable iff (rst)
        in_valid_i && (in_i.ctrl.mem_read || in_i.ctrl.mem_write) &&
        (in_i.ctrl.mem_size inside {mem_h, mem_hu}) |-> !in_i.alu_out[0])
        else $error("mem_stage: misaligned half access");

    assert property (@(posedge clk) disable iff (rst)
        in_valid_i && (in_i.ctrl.mem_read || in_i.ctrl.mem_write) &&
        (in_i.ctrl.mem_size == mem_w) |-> in_i.alu_out[1:0] == 2'b00)
        else $error("mem_stage: misaligned word access");

    assert property (@(posedge clk) disable iff (rst)
        in_valid_i |-> !(in_i.ctrl.mem_read && in_i.ctrl.mem_write))
        else $error("mem_stage: load and store together");

endmodule : mem_stage

/* logic/ex_mem_reg.sv */
module ex_mem_reg
import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    in_valid_i,
    output logic    in_ready_o,
    input  ex_mem_t in_i,

    output logic    out_valid_o,
    input  logic    out_ready_i,
    output ex_mem_t out_o
);

    logic    valid_q;
    ex_mem_t data_q;

    // Free when empty or draining this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else begin
            if (in_ready_o) begin
                valid_q <= in_valid_i;
            end
            if (in_valid_i && in_ready_o) begin
                data_q <= in_i;
            end
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

    // Stalled output keeps its record until taken
    assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
        else $error("ex_mem_reg: record changed while stalled");

endmodule : ex_mem_reg

/* logic/execute_stage.sv */
module execute_stage
import rv32i_pkg::*;
(
    input  logic    issue_valid_i,
    output logic    issue_ready_o,
    input  id_ex_t  issue_i,

    output logic    ex_valid_o,
    input  logic    ex_ready_i,
    output ex_mem_t ex_o
);

    rv32i_word op_a;
    rv32i_word op_b;
    logic [4:0] shamt;
    rv32i_word alu_out;
    logic br_taken;
    logic redirect_en;
    rv32i_word jalr_sum;
    rv32i_word redirect_pc;

    // Stateless stage so the handshake passes straight through
    assign ex_valid_o    = issue_valid_i;
    assign issue_ready_o = ex_ready_i;

    // Operand select
    assign op_a  = issue_i.ctrl.alu_src_pc ? issue_i.pc : issue_i.rs1_val;
    assign op_b  = issue_i.ctrl.alu_src_imm ? issue_i.imm : issue_i.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (issue_i.ctrl.alu_op)
            alu_add: begin
                alu_out = op_a + op_b;
            end
            alu_sub: begin
                alu_out = op_a - op_b;
            end
            alu_sll: begin
                alu_out = op_a << shamt;
            end
            alu_slt: begin
                alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_out = {31'b0, op_a < op_b};
            end
            alu_xor: begin
                alu_out = op_a ^ op_b;
            end
            alu_srl: begin
                alu_out = op_a >> shamt;
            end
            alu_sra: begin
                alu_out = rv32i_word'($signed(op_a) >>> shamt);
            end
            alu_or: begin
                alu_out = op_a | op_b;
            end
            alu_and: begin
                alu_out = op_a & op_b;
            end
            default: begin
                alu_out = op_a + op_b;
            end
        endcase
    end

    // Branch compare always on the register values
    always_comb begin
        unique case (issue_i.ctrl.cmp_op)
            cmp_beq:  br_taken = issue_i.rs1_val == issue_i.rs2_val;
            cmp_bne:  br_taken = issue_i.rs1_val != issue_i.rs2_val;
            cmp_blt:  br_taken = $signed(issue_i.rs1_val) < $signed(issue_i.rs2_val);
            cmp_bge:  br_taken = $signed(issue_i.rs1_val) >= $signed(issue_i.rs2_val);
            cmp_bltu: br_taken = issue_i.rs1_val < issue_i.rs2_val;
            cmp_bgeu: br_taken = issue_i.rs1_val >= issue_i.rs2_val;
            default:  br_taken = 1'b0;
        endcase
    end

    assign redirect_en = issue_i.ctrl.is_jal || issue_i.ctrl.is_jalr ||
                         (issue_i.ctrl.is_branch && br_taken);

    // jalr target drops bit 0
    assign jalr_sum    = issue_i.rs1_val + issue_i.imm;
    assign redirect_pc = issue_i.ctrl.is_jalr ? {jalr_sum[31:1], 1'b0}
                                              : issue_i.pc + issue_i.imm;

    always_comb begin
        ex_o.pc          = issue_i.pc;
        ex_o.ctrl        = issue_i.ctrl;
        ex_o.alu_out     = alu_out;
        ex_o.rs2_val     = issue_i.rs2_val;
        ex_o.rd          = issue_i.rd;
        ex_o.redirect_en = redirect_en;
        ex_o.redirect_pc = redirect_pc;
    end

endmodule : execute_stage

/* logic/rv32i_pkg.sv */
package rv32i_pkg;

    // Data memory geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;
    typedef logic [3:0]  byte_en_t;
    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

    // ALU operations encoded as {funct7[5], funct3} where it applies
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_ops;

    // Branch comparisons in funct3 encoding
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_ops;

    // Load and store sizes in funct3 encoding
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_funct3;

    typedef struct packed {
        alu_ops    alu_op;
        cmp_ops    cmp_op;
        logic      alu_src_imm;
        logic      alu_src_pc;
        logic      mem_read;
        logic      mem_write;
        mem_funct3 mem_size;
        logic      reg_write;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      halt;
    } rv32i_control_word;

    // Issue bundle from decode
    typedef struct packed {
        rv32i_word         pc;
        rv32i_control_word ctrl;
        rv32i_word         rs1_val;
        rv32i_word         rs2_val;
        rv32i_word         imm;
        rv32i_reg          rd;
    } id_ex_t;

    typedef struct packed {
        rv32i_word         pc;
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        rv32i_word         rs2_val;
        rv32i_reg          rd;
        logic              redirect_en;
        rv32i_word         redirect_pc;
    } ex_mem_t;

    // Writeback record
    typedef struct packed {
        rv32i_word pc;
        rv32i_reg  rd;
        logic      reg_write;
        rv32i_word wb_data;
        logic      redirect_en;
        rv32i_word redirect_pc;
        logic      halt;
    } wb_t;

endpackage : rv32i_pkg
